// File: source/board_pkg.sv
`default_nettype none

package board_pkg;

    // --------------------
    // Dynamic display bus

    typedef logic [7:0] seg_t;        // a..g then h, a is the MSB, positive logic
    typedef logic [3:0] digit_sel_t;  // One-hot digit select

    // --------------------
    // Static board digits

    typedef logic [6:0] hex_seg_t;    // Active low, bit 0 is segment a

    // --------------------
    // Displayed values

    typedef logic [3:0]  nibble_t;    // One hex digit
    typedef logic [15:0] count_t;     // Four hex digits

endpackage

`default_nettype wire

// File: source/audio_pkg.sv
`default_nettype none

package audio_pkg;

    typedef logic signed [23:0] mic_sample_t;  // Raw microphone word
    typedef logic signed [15:0] snd_sample_t;  // DAC word

    // Sample plus a one-cycle strobe, no ready since I2S never stalls
    typedef struct packed {
        snd_sample_t data;
        logic        valid;
    } snd_beat_t;

    typedef struct packed {
        mic_sample_t data;
        logic        valid;
    } mic_beat_t;

endpackage

`default_nettype wire

// File: source/tick_gen.sv
`default_nettype none

module tick_gen
#(
    parameter int tick_cycles = 50_000_000
)
(
    input  wire  clk,
    input  wire  rst,
    output logic tick
);

    localparam int w_cnt = $clog2(tick_cycles + 1);
    localparam logic [w_cnt - 1:0] cnt_load = w_cnt'(tick_cycles - 1);

    logic [w_cnt - 1:0] cnt;  // Cycles left until the next pulse

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cnt  <= cnt_load;
            tick <= 1'b0;
        end
        else if (cnt == '0)
        begin
            cnt  <= cnt_load;  // Reload and fire
            tick <= 1'b1;
        end
        else
        begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: source/seg_scan.sv
`default_nettype none

module seg_scan
    import board_pkg::*;
#(
    parameter int scan_cycles = 1024
)
(
    input  wire             clk,
    input  wire             rst,
    input  wire count_t     value,
    input  wire digit_sel_t dp,
    output seg_t            abcdefgh,
    output digit_sel_t      digit
);

    localparam int w_cnt = $clog2(scan_cycles + 1);
    localparam logic [w_cnt - 1:0] cnt_load = w_cnt'(scan_cycles - 1);

    logic [w_cnt - 1:0] scan_cnt;
    digit_sel_t         sel;     // Digit being driven next
    nibble_t            nibble;
    logic               dp_bit;

    // Returns segments a..g, a in bit 6
    function automatic logic [6:0] hex_font(input nibble_t n);
        logic [6:0] f;
        case (n)
            4'h0: f = 7'b1111110;
            4'h1: f = 7'b0110000;
            4'h2: f = 7'b1101101;
            4'h3: f = 7'b1111001;
            4'h4: f = 7'b0110011;
            4'h5: f = 7'b1011011;
            4'h6: f = 7'b1011111;
            4'h7: f = 7'b1110000;
            4'h8: f = 7'b1111111;
            4'h9: f = 7'b1111011;
            4'ha: f = 7'b1110111;
            4'hb: f = 7'b0011111;
            4'hc: f = 7'b1001110;
            4'hd: f = 7'b0111101;
            4'he: f = 7'b1001111;
            default: f = 7'b1000111;
        endcase
        return f;
    endfunction

    // --------------------
    // Digit rotation

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            scan_cnt <= cnt_load;
            sel      <= 4'b0001;
        end
        else if (scan_cnt == '0)
        begin
            scan_cnt <= cnt_load;
            sel      <= {sel[2:0], sel[3]};  // Digit 0 towards digit 3
        end
        else
        begin
            scan_cnt <= scan_cnt - 1'b1;
        end
    end

    always_comb
    begin
        nibble = '0;
        dp_bit = 1'b0;
        for (int i = 0; i < 4; i++)
        begin
            if (sel[i])
            begin
                nibble = value[4 * i +: 4];
                dp_bit = dp[i];
            end
        end
    end

    // Segments and select leave in the same register stage
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            abcdefgh <= '0;
            digit    <= '0;
        end
        else
        begin
            abcdefgh <= {hex_font(nibble), dp_bit};
            digit    <= sel;
        end
    end

endmodule

`default_nettype wire

// File: source/lab_top.sv
`default_nettype none

module lab_top
    import board_pkg::*, audio_pkg::*;
#(
    parameter int scan_cycles = 1024
)
(
    input  wire            clk,
    input  wire            rst,
    input  wire            tick,
    input  wire [3:0]      key,    // Active high here
    input  wire [8:0]      sw,
    output seg_t           abcdefgh,
    output digit_sel_t     digit,
    input  wire mic_beat_t mic,
    output snd_beat_t      sound
);

    count_t      cnt;
    snd_sample_t mic_top;
    snd_sample_t snd_data;
    logic        snd_valid;

    // --------------------
    // Hex counter

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            cnt <= '0;
        else if (key[1])
            cnt <= '0;                 // Clear wins over pause
        else if (tick && !key[0])
            cnt <= cnt + 1'b1;
    end

    seg_scan #(
        .scan_cycles (scan_cycles)
    ) u_seg_scan (
        .clk      (clk),
        .rst      (rst),
        .value    (cnt),
        .dp       ({key[0], 3'b000}),  // Digit 3 dp shows pause
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    // --------------------
    // Volume

    assign mic_top = mic.data[23:8];

    always_ff @(posedge clk)
    begin
        if (mic.valid)
            snd_data <= mic_top >>> sw[2:0];  // Sign-preserving attenuation
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            snd_valid <= 1'b0;
        else
            snd_valid <= mic.valid;
    end

    assign sound = '{data: snd_data, valid: snd_valid};

endmodule

`default_nettype wire

// File: source/seg_static_latch.sv
`default_nettype none

module seg_static_latch
    import board_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire seg_t       abcdefgh,
    input  wire digit_sel_t digit,
    output hex_seg_t        hex0,
    output hex_seg_t        hex1,
    output hex_seg_t        hex2,
    output hex_seg_t        hex3,
    output digit_sel_t      dp
);

    logic [7:0] hgfedcba;     // Bit 0 is segment a, bit 7 the point
    hex_seg_t   hex_q [4];

    always_comb
    begin
        for (int i = 0; i < 8; i++)
        begin
            hgfedcba[i] = abcdefgh[7 - i];
        end
    end

    // Each digit keeps its last scanned pattern
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < 4; i++)
            begin
                hex_q[i] <= '1;       // Blank
            end
            dp <= '0;
        end
        else
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (digit[i])
                begin
                    hex_q[i] <= ~hgfedcba[6:0];
                    dp[i]    <= hgfedcba[7];
                end
            end
        end
    end

    assign hex0 = hex_q[0];
    assign hex1 = hex_q[1];
    assign hex2 = hex_q[2];
    assign hex3 = hex_q[3];

endmodule

`default_nettype wire

// File: source/i2s_mic_rx.sv
`default_nettype none

module i2s_mic_rx
    import audio_pkg::*;
#(
    parameter int mic_sck_div = 8
)
(
    input  wire  clk,
    input  wire  rst,
    output logic sck,
    output logic ws,
    input  wire  sd,
    output mic_beat_t value
);

    localparam int w_div = $clog2(mic_sck_div + 1);
    localparam logic [w_div - 1:0] div_last = w_div'(mic_sck_div - 1);

    logic [w_div - 1:0] div_cnt;
    logic               sck_rise;
    logic               sck_fall;
    logic [5:0]         bit_cnt;   // 64 sck per stereo frame
    mic_sample_t        shreg;
    logic               word_done;

    // --------------------
    // Serial clocks

    assign sck_rise = (div_cnt == div_last) && !sck;
    assign sck_fall = (div_cnt == div_last) && sck;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
        end
        else if (div_cnt == div_last)
        begin
            div_cnt <= '0;
            sck     <= ~sck;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            bit_cnt <= '0;
        else if (sck_fall)
            bit_cnt <= bit_cnt + 1'b1;
    end

    assign ws = bit_cnt[5];          // Low half of the frame is left

    // --------------------
    // Left word capture

    // Slot 0 is the one-bit delay, slots 1..24 carry MSB first
    always_ff @(posedge clk)
    begin
        if (sck_rise && bit_cnt >= 6'd1 && bit_cnt <= 6'd24)
            shreg <= {shreg[22:0], sd};
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            word_done <= 1'b0;
        else
            word_done <= sck_rise && (bit_cnt == 6'd24);
    end

    assign value = '{data: shreg, valid: word_done};

endmodule

`default_nettype wire

// File: source/i2s_audio_tx.sv
`default_nettype none

module i2s_audio_tx
    import audio_pkg::*;
#(
    parameter int dac_bclk_div = 8
)
(
    input  wire            clk,
    input  wire            rst,
    input  wire snd_beat_t sound,
    output logic           mclk,
    output logic           bclk,
    output logic           lrclk,
    output logic           sdata
);

    localparam int w_div = $clog2(dac_bclk_div + 1);
    localparam logic [w_div - 1:0] div_last = w_div'(dac_bclk_div - 1);

    logic [w_div - 1:0] div_cnt;
    logic               bclk_fall;
    logic [4:0]         slot;      // 32 bclk per stereo frame
    logic [4:0]         slot_next;
    snd_sample_t        hold;      // Latest sample, overwritten mid-frame
    snd_sample_t        shreg;

    assign bclk_fall = (div_cnt == div_last) && bclk;
    assign slot_next = slot + 1'b1;
    assign lrclk     = slot[4];

    // --------------------
    // Clocks

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            mclk    <= 1'b0;
            bclk    <= 1'b0;
            div_cnt <= '0;
            slot    <= '0;
        end
        else
        begin
            mclk <= ~mclk;
            if (div_cnt == div_last)
            begin
                div_cnt <= '0;
                bclk    <= ~bclk;
            end
            else
            begin
                div_cnt <= div_cnt + 1'b1;
            end
            if (bclk_fall)
                slot <= slot_next;
        end
    end

    // --------------------
    // Data

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            hold  <= '0;
            shreg <= '0;
            sdata <= 1'b0;
        end
        else
        begin
            if (sound.valid)
                hold <= sound.data;
            if (bclk_fall)
            begin
                sdata <= shreg[15];       // MSB lands one bclk after the lrclk edge
                if (slot_next[3:0] == 4'd0)
                    shreg <= hold;        // Same sample for left and right
                else
                    shreg <= {shreg[14:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

// File: source/board_top.sv
`default_nettype none

module board_top
    import board_pkg::*, audio_pkg::*;
#(
    parameter int tick_cycles  = 50_000_000,
    parameter int scan_cycles  = 1024,
    parameter int mic_sck_div  = 8,
    parameter int dac_bclk_div = 8
)
(
    input  wire        clk,
    input  wire        rst,
    input  wire [3:0]  key,       // Active low
    input  wire [8:0]  sw,
    output digit_sel_t led,       // Decimal points
    output hex_seg_t   hex0,
    output hex_seg_t   hex1,
    output hex_seg_t   hex2,
    output hex_seg_t   hex3,
    output wire        mic_lr,
    output wire        mic_ws,
    output wire        mic_sck,
    input  wire        mic_sd,
    output wire        aud_mclk,
    output wire        aud_bclk,
    output wire        aud_lrclk,
    output wire        aud_sdata
);

    wire             tick;
    wire [3:0]       lab_key;
    wire seg_t       abcdefgh;
    wire digit_sel_t digit;
    wire mic_beat_t  mic;
    wire snd_beat_t  sound;

    assign lab_key = ~key;
    assign mic_lr  = 1'b0;        // Left channel

    tick_gen #(
        .tick_cycles (tick_cycles)
    ) u_tick_gen (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    lab_top #(
        .scan_cycles (scan_cycles)
    ) u_lab_top (
        .clk      (clk),
        .rst      (rst),
        .tick     (tick),
        .key      (lab_key),
        .sw       (sw),
        .abcdefgh (abcdefgh),
        .digit    (digit),
        .mic      (mic),
        .sound    (sound)
    );

    seg_static_latch u_seg_static_latch (
        .clk      (clk),
        .rst      (rst),
        .abcdefgh (abcdefgh),
        .digit    (digit),
        .hex0     (hex0),
        .hex1     (hex1),
        .hex2     (hex2),
        .hex3     (hex3),
        .dp       (led)
    );

    i2s_mic_rx #(
        .mic_sck_div (mic_sck_div)
    ) u_i2s_mic_rx (
        .clk   (clk),
        .rst   (rst),
        .sck   (mic_sck),
        .ws    (mic_ws),
        .sd    (mic_sd),
        .value (mic)
    );

    i2s_audio_tx #(
        .dac_bclk_div (dac_bclk_div)
    ) u_i2s_audio_tx (
        .clk   (clk),
        .rst   (rst),
        .sound (sound),
        .mclk  (aud_mclk),
        .bclk  (aud_bclk),
        .lrclk (aud_lrclk),
        .sdata (aud_sdata)
    );

endmodule

`default_nettype wire

// File: test/tb_board_top.sv
`default_nettype none

module tb_board_top;

    localparam int tick_cycles  = 64;
    localparam int scan_cycles  = 4;
    localparam int mic_sck_div  = 2;
    localparam int dac_bclk_div = 2;
    localparam int scan_bound   = 4 * scan_cycles + 2;
    localparam int frame_cycles = 128 * mic_sck_div;    // One mic ws period

    logic        clk = 1'b0;
    logic        rst;
    logic [3:0]  key;
    logic [8:0]  sw;
    logic        mic_sd = 1'b0;
    logic [3:0]  led;
    logic [6:0]  hex0;
    logic [6:0]  hex1;
    logic [6:0]  hex2;
    logic [6:0]  hex3;
    wire         mic_lr;
    wire         mic_ws;
    wire         mic_sck;
    wire         aud_mclk;
    wire         aud_bclk;
    wire         aud_lrclk;
    wire         aud_sdata;

    logic [15:0] ref_count = 16'h0000;
    logic [23:0] mic_word = 24'h000000;    // Word the mic sends from the next left slot
    logic [15:0] left_words [$];           // Decoded DAC left channel
    int          exp_index [$];
    logic [15:0] exp_sound [$];

    board_top #(
        .tick_cycles  (tick_cycles),
        .scan_cycles  (scan_cycles),
        .mic_sck_div  (mic_sck_div),
        .dac_bclk_div (dac_bclk_div)
    ) u_board_top (
        .clk       (clk),
        .rst       (rst),
        .key       (key),
        .sw        (sw),
        .led       (led),
        .hex0      (hex0),
        .hex1      (hex1),
        .hex2      (hex2),
        .hex3      (hex3),
        .mic_lr    (mic_lr),
        .mic_ws    (mic_ws),
        .mic_sck   (mic_sck),
        .mic_sd    (mic_sd),
        .aud_mclk  (aud_mclk),
        .aud_bclk  (aud_bclk),
        .aud_lrclk (aud_lrclk),
        .aud_sdata (aud_sdata)
    );

    always #4 clk = ~clk;

    // --------------------
    // Reference functions

    // Bit 0 is segment a, bit 6 is segment g
    function automatic logic [6:0] segment_font(input logic [3:0] n);
        case (n)
            4'h0: return 7'b0111111;
            4'h1: return 7'b0000110;
            4'h2: return 7'b1011011;
            4'h3: return 7'b1001111;
            4'h4: return 7'b1100110;
            4'h5: return 7'b1101101;
            4'h6: return 7'b1111101;
            4'h7: return 7'b0000111;
            4'h8: return 7'b1111111;
            4'h9: return 7'b1101111;
            4'ha: return 7'b1110111;
            4'hb: return 7'b1111100;
            4'hc: return 7'b0111001;
            4'hd: return 7'b1011110;
            4'he: return 7'b1111001;
            default: return 7'b1110001;
        endcase
    endfunction

    function automatic logic [6:0] static_pattern(input logic [3:0] n);
        return ~segment_font(n);                 // Board digits are active low
    endfunction

    function automatic logic [15:0] sound_reference(input logic [23:0] word, input logic [2:0] sh);
        logic signed [15:0] top;
        top = word[23:8];
        return top >>> sh;
    endfunction

    function automatic bit display_is(input logic [15:0] value);
        return hex0 == static_pattern(value[3:0]) && hex1 == static_pattern(value[7:4])
            && hex2 == static_pattern(value[11:8]) && hex3 == static_pattern(value[15:12]);
    endfunction

    // --------------------
    // Checks

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("[ERROR] %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_display(input logic [15:0] value);
        logic [6:0] shown [4];
        shown[0] = hex0;
        shown[1] = hex1;
        shown[2] = hex2;
        shown[3] = hex3;
        for (int i = 0; i < 4; i++)
            check_value($sformatf("hex%0d", i), 32'(shown[i]),
                        32'(static_pattern(value[4 * i +: 4])));
    endtask

    // Blank digits, dark points and quiet serial lines
    task automatic verify_reset_outputs();
        check_value("hex0", 32'(hex0), 32'h7f);
        check_value("hex1", 32'(hex1), 32'h7f);
        check_value("hex2", 32'(hex2), 32'h7f);
        check_value("hex3", 32'(hex3), 32'h7f);
        check_value("led", 32'(led), 32'h0);
        check_value("mic_lr", 32'(mic_lr), 32'h0);
        check_value("mic_sck", 32'(mic_sck), 32'h0);
        check_value("mic_ws", 32'(mic_ws), 32'h0);
        check_value("aud_mclk", 32'(aud_mclk), 32'h0);
        check_value("aud_bclk", 32'(aud_bclk), 32'h0);
        check_value("aud_lrclk", 32'(aud_lrclk), 32'h0);
        check_value("aud_sdata", 32'(aud_sdata), 32'h0);
    endtask

    task automatic wait_display(input logic [15:0] value, input int limit);
        int n;
        n = 0;
        while (!display_is(value) && n < limit)
        begin
            @(negedge clk);
            n++;
        end
        assert (display_is(value))
        else
        begin
            $display("Display did not settle on %h within %0d cycles", value, limit);
            abort_run();
        end
    endtask

    // Follow the counter for a number of ticks, one step each
    task automatic count_steps(input int steps);
        int n;
        for (int s = 0; s < steps; s++)
        begin
            n = 0;
            while (display_is(ref_count) && n < 2 * tick_cycles)
            begin
                @(negedge clk);
                n++;
            end
            assert (!display_is(ref_count))
            else
            begin
                $display("Display stayed at %h with the keys released", ref_count);
                abort_run();
            end
            ref_count = ref_count + 16'd1;
            wait_display(ref_count, scan_bound);
        end
    endtask

    task automatic wait_ws_edge(input logic level);
        int   n;
        logic prev;
        n    = 0;
        prev = mic_ws;
        @(negedge clk);
        while (!(mic_ws == level && prev != level) && n < 4 * frame_cycles)
        begin
            prev = mic_ws;
            @(negedge clk);
            n++;
        end
        assert (mic_ws == level && prev != level)
        else
        begin
            $display("Timeout while waiting for mic_ws to change to %0b", level);
            abort_run();
        end
    endtask

    task automatic wait_compared();
        int n;
        n = 0;
        while (exp_index.size() != 0 && n < 4 * frame_cycles)
        begin
            @(negedge clk);
            n++;
        end
        assert (exp_index.size() == 0)
        else
        begin
            $display("Timeout while waiting for the DAC left words");
            abort_run();
        end
    endtask

    task automatic audio_case(input logic [23:0] word, input logic [2:0] sh);
        int base;
        wait_ws_edge(1'b1);                      // Change inputs in the right half
        mic_word = word;
        sw       = {6'b000000, sh};
        wait_ws_edge(1'b0);
        base = left_words.size();
        exp_index.push_back(base + 2);           // Third left word after the new frame
        exp_sound.push_back(sound_reference(word, sh));
        wait_compared();
    endtask

    // --------------------
    // Microphone model and DAC decoder

    logic [23:0] mic_latched = 24'h000000;
    int          mic_pos = 24;
    logic        mic_last_sck = 1'b0;
    logic        mic_last_ws = 1'b0;

    always @(negedge clk)
    begin
        if (!mic_sck && mic_last_sck)
        begin
            if (!mic_ws && mic_last_ws)
            begin
                mic_latched = mic_word;
                mic_pos     = 0;                 // One-bit delay slot
                mic_sd      = 1'b0;
            end
            else if (mic_pos < 24)
            begin
                mic_sd  = mic_latched[23 - mic_pos];
                mic_pos = mic_pos + 1;
            end
            else
                mic_sd = 1'b0;
        end
        mic_last_sck = mic_sck;
        mic_last_ws  = mic_ws;
    end

    logic        dac_last_bclk = 1'b0;
    logic        dac_last_lr = 1'b0;
    int          dac_idx = 99;                   // Idle until the first lrclk fall
    logic [15:0] dac_shift = 16'h0000;

    always @(negedge clk)
    begin
        if (aud_bclk && !dac_last_bclk)
        begin
            if (!aud_lrclk && dac_last_lr)
                dac_idx = 0;
            else if (dac_idx < 99)
                dac_idx = dac_idx + 1;
            if (dac_idx >= 1 && dac_idx <= 16)
                dac_shift = {dac_shift[14:0], aud_sdata};
            if (dac_idx == 16)
                left_words.push_back(dac_shift);
            dac_last_lr = aud_lrclk;
        end
        dac_last_bclk = aud_bclk;
    end

    // Compare process for the audio path
    always @(negedge clk)
    begin
        if (exp_index.size() != 0 && left_words.size() > exp_index[0])
        begin
            check_value("aud_sdata", 32'(left_words[exp_index[0]]), 32'(exp_sound[0]));
            void'(exp_index.pop_front());
            void'(exp_sound.pop_front());
        end
    end

    // --------------------
    // Stimulus

    initial
    begin
        logic mclk_prev;
        rst        = 1'b1;
        key        = 4'b1111;
        sw         = 9'h000;
        void'($urandom(36));
        repeat (5) @(negedge clk);
        verify_reset_outputs();
        rst = 1'b0;
        for (int n = 0; n < 4; n++)
        begin
            mclk_prev = aud_mclk;
            @(negedge clk);
            check_value("aud_mclk", 32'(aud_mclk), 32'(!mclk_prev));
        end
        wait_display(16'h0000, scan_bound);
        check_value("led", 32'(led), 32'h0);
        count_steps(3);

        key = 4'b1110;                           // Pause
        for (int n = 0; n < 4 * tick_cycles; n++)
        begin
            @(negedge clk);
            check_display(ref_count);
            if (n >= scan_bound)
                check_value("led", 32'(led), 32'h8);
        end
        key = 4'b1111;
        count_steps(2);
        check_value("led", 32'(led), 32'h0);

        key = 4'b1101;                           // Clear
        wait_display(16'h0000, scan_bound);
        for (int n = 0; n < 2 * tick_cycles; n++)
        begin
            @(negedge clk);
            check_display(16'h0000);
        end
        key       = 4'b1111;
        ref_count = 16'h0000;
        count_steps(3);

        audio_case(24'h800000, 3'd0);
        audio_case(24'h800000, 3'd7);
        audio_case(24'h7fff00, 3'd3);
        for (int c = 0; c < 6; c++)
            audio_case(24'($urandom()), 3'($urandom()));

        key = 4'b1101;                           // Restart from zero for the wrap
        wait_display(16'h0000, scan_bound);
        key       = 4'b1111;
        ref_count = 16'h0000;
        count_steps(65536);                      // Full wrap through ffff
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
source/board_pkg.sv
source/audio_pkg.sv
source/tick_gen.sv
source/seg_scan.sv
source/lab_top.sv
source/seg_static_latch.sv
source/i2s_mic_rx.sv
source/i2s_audio_tx.sv
source/board_top.sv
test/tb_board_top.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the board_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module tb_board_top -o tb_board_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_board_top)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^TEST RESULT: PASS$"; then
    exit 0
fi
exit 1
